// File: bus_pkg.sv
package bus_pkg;

  // ------------------------------------------------------------
  // APB transfer structs
  // ------------------------------------------------------------

  // One request as driven by a master
  typedef struct packed {
    logic        sel;
    logic        enable;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
  } apb_req_t;

  // Completion and read data from a slave
  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
    logic        slverr;
  } apb_rsp_t;

  // ------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------

  // Area prefixes live in addr[31:30], areas 0 and 2 are unmapped
  localparam logic [1:0] RAM_AREA  = 2'd1;
  localparam logic [1:0] MMIO_AREA = 2'd3;

  // Core prefixes inside the MMIO area, addr[29:24]
  localparam logic [5:0] TIMER_CORE  = 6'h01;
  localparam logic [5:0] FW_RAM_CORE = 6'h10;
  localparam logic [5:0] MODE_CORE   = 6'h3f;

endpackage

// File: reg_pkg.sv
package reg_pkg;

  // Mode controller word offsets
  localparam logic [7:0] MODE_ID_REG  = 8'd0;
  localparam logic [7:0] MODE_APP_REG = 8'd2;
  localparam logic [7:0] MODE_KEY_REG = 8'd4;

  // Read-only identifier, "apps" in ASCII
  localparam logic [31:0] MODE_ID_VALUE = 32'h61707073;

  // Timer word offsets
  localparam logic [7:0] TIMER_CTRL_REG     = 8'd0;
  localparam logic [7:0] TIMER_STATUS_REG   = 8'd1;
  localparam logic [7:0] TIMER_PRESCALE_REG = 8'd2;
  localparam logic [7:0] TIMER_INITIAL_REG  = 8'd3;
  localparam logic [7:0] TIMER_COUNT_REG    = 8'd4;

  // Timer control register bits
  localparam int TIMER_START_BIT = 0;
  localparam int TIMER_STOP_BIT  = 1;

endpackage

// File: apb_arbiter.sv
module apb_arbiter (
  input  logic              clk,
  input  logic              reset_n,
  input  bus_pkg::apb_req_t host_req,
  output bus_pkg::apb_rsp_t host_rsp,
  input  bus_pkg::apb_req_t load_req,
  output bus_pkg::apb_rsp_t load_rsp,
  output bus_pkg::apb_req_t bus_req,
  input  bus_pkg::apb_rsp_t bus_rsp
);
  import bus_pkg::*;

  // Owner and last winner, 0 is host and 1 is loader
  logic     busy_reg;
  logic     owner_reg;
  logic     last_reg;
  logic     cur_owner;
  logic     cur_valid;
  logic     done;
  apb_req_t owner_req;

  // ------------------------------------------------------------
  // Grant selection
  // ------------------------------------------------------------
  always_comb begin
    if (busy_reg) begin
      cur_owner = owner_reg;
      cur_valid = 1'b1;
    end else if (host_req.sel && load_req.sel) begin
      // Contention goes to whoever did not win last
      cur_owner = !last_reg;
      cur_valid = 1'b1;
    end else begin
      cur_owner = !host_req.sel;
      cur_valid = host_req.sel || load_req.sel;
    end
  end

  // A fresh grant always starts with a setup phase on the bus,
  // even if the waiting master is already in its access phase
  always_comb begin
    owner_req      = cur_owner ? load_req : host_req;
    bus_req        = owner_req;
    bus_req.sel    = cur_valid;
    bus_req.enable = owner_req.enable && busy_reg;
  end

  assign done = busy_reg && bus_rsp.ready;

  // Response goes back to the owner only
  always_comb begin
    host_rsp = '0;
    load_rsp = '0;
    if (busy_reg) begin
      if (owner_reg) begin
        load_rsp = bus_rsp;
      end else begin
        host_rsp = bus_rsp;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      busy_reg  <= 1'b0;
      owner_reg <= 1'b0;
      last_reg  <= 1'b1;
    end else if (done) begin
      busy_reg <= 1'b0;
    end else if (!busy_reg && cur_valid) begin
      busy_reg  <= 1'b1;
      owner_reg <= cur_owner;
      last_reg  <= cur_owner;
    end
  end

endmodule

// File: addr_decoder.sv
module addr_decoder (
  input  bus_pkg::apb_req_t bus_req,
  output bus_pkg::apb_rsp_t bus_rsp,
  input  logic [31:0]       scramble_key,
  output bus_pkg::apb_req_t ram_req,
  output bus_pkg::apb_req_t timer_req,
  output bus_pkg::apb_req_t fw_req,
  output bus_pkg::apb_req_t mode_req,
  input  bus_pkg::apb_rsp_t ram_rsp,
  input  bus_pkg::apb_rsp_t timer_rsp,
  input  bus_pkg::apb_rsp_t fw_rsp,
  input  bus_pkg::apb_rsp_t mode_rsp
);
  import bus_pkg::*;

  logic [1:0]  area;
  logic [5:0]  core;
  logic [31:0] mask;
  logic        access;

  assign area   = bus_req.addr[31:30];
  assign core   = bus_req.addr[29:24];
  assign access = bus_req.sel && bus_req.enable;

  // Address dependent scramble mask for the main RAM
  assign mask = scramble_key ^ {2{bus_req.addr[15:0]}};

  // ------------------------------------------------------------
  // Slave select and response mux
  // ------------------------------------------------------------
  always_comb begin
    ram_req         = bus_req;
    ram_req.sel     = 1'b0;
    ram_req.wdata   = bus_req.wdata ^ mask;
    timer_req       = bus_req;
    timer_req.sel   = 1'b0;
    fw_req          = bus_req;
    fw_req.sel      = 1'b0;
    mode_req        = bus_req;
    mode_req.sel    = 1'b0;

    // Unmapped answers at once with an error
    bus_rsp.ready  = access;
    bus_rsp.slverr = access;
    bus_rsp.rdata  = 32'h0;

    case (area)
      RAM_AREA: begin
        ram_req.sel   = bus_req.sel;
        bus_rsp       = ram_rsp;
        bus_rsp.rdata = ram_rsp.rdata ^ mask;
      end
      MMIO_AREA: begin
        case (core)
          TIMER_CORE: begin
            timer_req.sel = bus_req.sel;
            bus_rsp       = timer_rsp;
          end
          FW_RAM_CORE: begin
            fw_req.sel = bus_req.sel;
            bus_rsp    = fw_rsp;
          end
          MODE_CORE: begin
            mode_req.sel = bus_req.sel;
            bus_rsp      = mode_rsp;
          end
          default: begin
          end
        endcase
      end
      default: begin
      end
    endcase
  end

endmodule

// File: word_ram.sv
module word_ram #(
  parameter int DEPTH = 256
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              write_lock,
  input  bus_pkg::apb_req_t req,
  output bus_pkg::apb_rsp_t rsp
);

  localparam int AW = $clog2(DEPTH);

  logic [31:0]   mem [DEPTH];
  logic [AW-1:0] idx;
  logic          access;
  logic          first;
  logic          ready_reg;
  logic          err_reg;
  logic [31:0]   rdata_reg;

  assign idx    = req.addr[AW+1:2];
  assign access = req.sel && req.enable;

  // First access cycle, completion follows one cycle later
  assign first = access && !ready_reg;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready_reg <= 1'b0;
      err_reg   <= 1'b0;
    end else begin
      ready_reg <= first;
      err_reg   <= first && req.write && write_lock;
    end
  end

  // ------------------------------------------------------------
  // Storage with byte strobes
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (first) begin
      rdata_reg <= mem[idx];
      if (req.write && !write_lock) begin
        for (int b = 0; b < 4; b++) begin
          if (req.strb[b]) begin
            mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  assign rsp.ready  = ready_reg;
  assign rsp.slverr = err_reg;
  assign rsp.rdata  = rdata_reg;

endmodule

// File: timer_core.sv
module timer_core (
  input  logic              clk,
  input  logic              reset_n,
  input  bus_pkg::apb_req_t req,
  output bus_pkg::apb_rsp_t rsp
);
  import reg_pkg::*;

  logic [31:0] prescale_reg;
  logic [31:0] initial_reg;
  logic [31:0] count_reg;
  logic [31:0] tick_reg;
  logic        running_reg;
  logic        access;
  logic        wr;
  logic [7:0]  offset;

  assign access = req.sel && req.enable;
  assign wr     = access && req.write;
  assign offset = req.addr[9:2];

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      prescale_reg <= 32'h0;
      initial_reg  <= 32'h0;
      count_reg    <= 32'h0;
      tick_reg     <= 32'h0;
      running_reg  <= 1'b0;
    end else if (wr && offset == TIMER_CTRL_REG) begin
      if (req.wdata[TIMER_START_BIT]) begin
        count_reg   <= initial_reg;
        tick_reg    <= 32'h0;
        running_reg <= 1'b1;
      end
      if (req.wdata[TIMER_STOP_BIT]) begin
        running_reg <= 1'b0;
      end
    end else begin
      if (wr && offset == TIMER_PRESCALE_REG) begin
        prescale_reg <= req.wdata;
      end
      if (wr && offset == TIMER_INITIAL_REG) begin
        initial_reg <= req.wdata;
      end
      // One count step every prescale + 1 cycles
      if (running_reg) begin
        if (count_reg == 32'h0) begin
          running_reg <= 1'b0;
        end else if (tick_reg == prescale_reg) begin
          tick_reg  <= 32'h0;
          count_reg <= count_reg - 32'd1;
          if (count_reg == 32'd1) begin
            running_reg <= 1'b0;
          end
        end else begin
          tick_reg <= tick_reg + 32'd1;
        end
      end
    end
  end

  // Register read mux
  always_comb begin
    case (offset)
      TIMER_STATUS_REG:   rsp.rdata = {31'h0, running_reg};
      TIMER_PRESCALE_REG: rsp.rdata = prescale_reg;
      TIMER_INITIAL_REG:  rsp.rdata = initial_reg;
      TIMER_COUNT_REG:    rsp.rdata = count_reg;
      default:            rsp.rdata = 32'h0;
    endcase
  end

  assign rsp.ready  = access;
  assign rsp.slverr = 1'b0;

endmodule

// File: mode_ctrl.sv
module mode_ctrl (
  input  logic              clk,
  input  logic              reset_n,
  input  bus_pkg::apb_req_t req,
  output bus_pkg::apb_rsp_t rsp,
  output logic              fw_app_mode,
  output logic [31:0]       scramble_key
);
  import reg_pkg::*;

  logic        app_mode_reg;
  logic [31:0] key_reg;
  logic        access;
  logic        wr;
  logic [7:0]  offset;
  logic        key_locked;

  assign access = req.sel && req.enable;
  assign wr     = access && req.write;
  assign offset = req.addr[9:2];

  // Key is frozen once application mode is entered
  assign key_locked = wr && offset == MODE_KEY_REG && app_mode_reg;

  // ------------------------------------------------------------
  // Mode flag and key
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      app_mode_reg <= 1'b0;
      key_reg      <= 32'h0;
    end else begin
      // One-way switch, only reset returns to firmware mode
      if (wr && offset == MODE_APP_REG) begin
        app_mode_reg <= 1'b1;
      end
      if (wr && offset == MODE_KEY_REG && !app_mode_reg) begin
        key_reg <= req.wdata;
      end
    end
  end

  always_comb begin
    case (offset)
      MODE_ID_REG:  rsp.rdata = MODE_ID_VALUE;
      MODE_APP_REG: rsp.rdata = {31'h0, app_mode_reg};
      default:      rsp.rdata = 32'h0;
    endcase
  end

  assign rsp.ready  = access;
  assign rsp.slverr = key_locked;

  assign fw_app_mode  = app_mode_reg;
  assign scramble_key = key_reg;

endmodule

// File: app_soc_top.sv
module app_soc_top #(
  parameter int RAM_WORDS    = 256,
  parameter int FW_RAM_WORDS = 64
) (
  input  logic              clk,
  input  logic              reset_n,
  input  bus_pkg::apb_req_t host_req,
  output bus_pkg::apb_rsp_t host_rsp,
  input  bus_pkg::apb_req_t load_req,
  output bus_pkg::apb_rsp_t load_rsp
);
  import bus_pkg::*;

  apb_req_t    bus_req;
  apb_rsp_t    bus_rsp;
  apb_req_t    ram_req;
  apb_rsp_t    ram_rsp;
  apb_req_t    timer_req;
  apb_rsp_t    timer_rsp;
  apb_req_t    fw_req;
  apb_rsp_t    fw_rsp;
  apb_req_t    mode_req;
  apb_rsp_t    mode_rsp;
  logic        fw_app_mode;
  logic [31:0] scramble_key;

  // ------------------------------------------------------------
  // Bus sharing and decode
  // ------------------------------------------------------------
  apb_arbiter arbiter_inst (
    .clk      (clk),
    .reset_n  (reset_n),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .load_req (load_req),
    .load_rsp (load_rsp),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp)
  );

  addr_decoder decoder_inst (
    .bus_req      (bus_req),
    .bus_rsp      (bus_rsp),
    .scramble_key (scramble_key),
    .ram_req      (ram_req),
    .timer_req    (timer_req),
    .fw_req       (fw_req),
    .mode_req     (mode_req),
    .ram_rsp      (ram_rsp),
    .timer_rsp    (timer_rsp),
    .fw_rsp       (fw_rsp),
    .mode_rsp     (mode_rsp)
  );

  // ------------------------------------------------------------
  // Peripherals
  // ------------------------------------------------------------
  word_ram #(.DEPTH(RAM_WORDS)) ram_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .write_lock (1'b0),
    .req        (ram_req),
    .rsp        (ram_rsp)
  );

  // Firmware RAM is read-only in application mode
  word_ram #(.DEPTH(FW_RAM_WORDS)) fw_ram_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .write_lock (fw_app_mode),
    .req        (fw_req),
    .rsp        (fw_rsp)
  );

  timer_core timer_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (timer_req),
    .rsp     (timer_rsp)
  );

  mode_ctrl mode_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .req          (mode_req),
    .rsp          (mode_rsp),
    .fw_app_mode  (fw_app_mode),
    .scramble_key (scramble_key)
  );

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen (
  output logic clk,
  output logic reset_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset held low for 8 cycles, released on a falling edge
  initial begin
    reset_n = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
  end

endmodule

// File: tb_app_soc.sv
module tb_app_soc;
  timeunit 1ns;
  timeprecision 1ps;
  import bus_pkg::*;
  import reg_pkg::*;

  localparam int RAM_WORDS    = 256;
  localparam int FW_RAM_WORDS = 64;
  localparam int N_ADDR       = 16;
  localparam int N_ROUNDS     = 8;
  // Transfers outside the RAM loops and the timer polling
  localparam int N_FIXED      = 31;
  localparam int NUM_XFERS    = 4 * N_ADDR + 3 * N_ROUNDS + N_FIXED;
  localparam logic [31:0] RAM_BASE   = 32'h4000_0000;
  localparam logic [31:0] TIMER_BASE = 32'hc100_0000;
  localparam logic [31:0] FW_BASE    = 32'hd000_0000;
  localparam logic [31:0] MODE_BASE  = 32'hff00_0000;

  typedef struct {
    string       name;
    logic [31:0] got;
    logic [31:0] exp;
  } compare_item_t;

  logic          clk;
  logic          reset_n;
  apb_req_t      host_req;
  apb_rsp_t      host_rsp;
  apb_req_t      load_req;
  apb_rsp_t      load_rsp;
  logic [31:0]   rand_state;
  int            error_count;
  bit            track_order;
  bit            order_q[$];
  compare_item_t results[$];

  // Reference model state
  logic [31:0] ram_store [RAM_WORDS];
  logic [31:0] fw_store [FW_RAM_WORDS];
  logic        app_mode;
  logic [31:0] key;

  tb_clock_gen clock_inst (
    .clk     (clk),
    .reset_n (reset_n)
  );

  app_soc_top #(.RAM_WORDS(RAM_WORDS), .FW_RAM_WORDS(FW_RAM_WORDS)) app_soc_top_inst (
    .clk      (clk),
    .reset_n  (reset_n),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .load_req (load_req),
    .load_rsp (load_rsp)
  );

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rand_state = xorshift(rand_state);
    return rand_state;
  endfunction

  function automatic logic [31:0] scramble_mask(input logic [31:0] addr);
    return key ^ {2{addr[15:0]}};
  endfunction

  // Expected read data from the main RAM
  function automatic logic [31:0] expected_ram_read(input logic [31:0] addr);
    return ram_store[addr[9:2]] ^ scramble_mask(addr);
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("error at %0d ns: %s got %h expected %h", $time, name, got, exp);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic drive_master(input bit master, input apb_req_t r);
    if (master) begin
      load_req = r;
    end else begin
      host_req = r;
    end
  endtask

  // One APB transfer, setup then access until ready
  task automatic apb_xfer(input bit master, input bit write, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] strb,
                          output logic [31:0] rdata, output logic err);
    apb_req_t r;
    apb_rsp_t s;
    r.sel    = 1'b1;
    r.enable = 1'b0;
    r.write  = write;
    r.addr   = addr;
    r.wdata  = wdata;
    r.strb   = strb;
    @(negedge clk);
    drive_master(master, r);
    @(negedge clk);
    r.enable = 1'b1;
    drive_master(master, r);
    do begin
      #1;
      s = master ? load_rsp : host_rsp;
      if (!s.ready) @(negedge clk);
    end while (!s.ready);
    rdata = s.rdata;
    err   = s.slverr;
    if (track_order) order_q.push_back(master);
    @(negedge clk);
    drive_master(master, '0);
  endtask

  task automatic expect_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    results.push_back('{name, got, exp});
  endtask

  task automatic reg_write(input bit master, input logic [31:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] rd;
    logic        err;
    apb_xfer(master, 1'b1, addr, data, 4'hf, rd, err);
    expect_val($sformatf("slverr wr %h", addr), {31'h0, err}, {31'h0, exp_err});
  endtask

  task automatic reg_read(input bit master, input logic [31:0] addr, input logic [31:0] exp,
                          input logic exp_err);
    logic [31:0] rd;
    logic        err;
    apb_xfer(master, 1'b0, addr, 32'h0, 4'h0, rd, err);
    expect_val($sformatf("rdata %h", addr), rd, exp);
    expect_val($sformatf("slverr rd %h", addr), {31'h0, err}, {31'h0, exp_err});
  endtask

  task automatic ram_write(input bit master, input int idx, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] addr;
    logic [31:0] sd;
    addr = RAM_BASE + idx * 4;
    sd   = data ^ scramble_mask(addr);
    reg_write_strb(master, addr, data, strb);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) ram_store[idx][8*b +: 8] = sd[8*b +: 8];
    end
  endtask

  task automatic reg_write_strb(input bit master, input logic [31:0] addr,
                                input logic [31:0] data, input logic [3:0] strb);
    logic [31:0] rd;
    logic        err;
    apb_xfer(master, 1'b1, addr, data, strb, rd, err);
    expect_val("ram slverr", {31'h0, err}, 32'h0);
  endtask

  task automatic ram_read(input bit master, input int idx);
    logic [31:0] rd;
    logic        err;
    logic [31:0] addr;
    addr = RAM_BASE + idx * 4;
    apb_xfer(master, 1'b0, addr, 32'h0, 4'h0, rd, err);
    expect_val($sformatf("ram rdata %h", addr), rd, expected_ram_read(addr));
  endtask

  // ------------------------------------------------------------
  // Compare process and watchdog
  // ------------------------------------------------------------
  initial begin
    compare_item_t item;
    forever begin
      wait (results.size() > 0);
      item = results.pop_front();
      check(item.name, item.got, item.exp);
    end
  end

  initial begin
    #((NUM_XFERS * 10 + 2000) * 8);
    $display("timeout: the run did not finish in time");
    $display("*** FAILED ***");
    $fatal(1);
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin
    time         t0;
    logic [31:0] stat;
    logic [31:0] rd;
    logic        err;
    int          bound;
    int          elapsed;
    host_req    = '0;
    load_req    = '0;
    rand_state  = 32'heeb4b01b;
    error_count = 0;
    track_order = 1'b0;
    app_mode    = 1'b0;
    key         = 32'h0;
    @(posedge reset_n);

    // Random RAM writes and reads through both masters
    for (int i = 0; i < N_ADDR; i++) ram_write(i[0], i, next_rand(), 4'hf);
    for (int i = 0; i < N_ADDR; i++) ram_write(!i[0], i, next_rand(), 4'(next_rand()));
    for (int i = 0; i < N_ADDR; i++) begin
      ram_read(1'b0, i);
      ram_read(1'b1, i);
    end

    // Contention, completions alternate
    track_order = 1'b1;
    for (int i = 0; i < N_ROUNDS; i++) begin
      // Lone transfer sets the last winner before the contention
      ram_read(i[0], next_rand() % N_ADDR);
      fork
        ram_read(1'b0, next_rand() % N_ADDR);
        ram_read(1'b1, next_rand() % N_ADDR);
      join
    end
    track_order = 1'b0;
    for (int i = 1; i < order_q.size(); i++) begin
      expect_val("completion order", {31'h0, order_q[i]}, {31'h0, !order_q[i-1]});
    end

    // New key, old words read back with the new mask
    reg_write(1'b0, MODE_BASE + MODE_KEY_REG * 4, 32'h5a5a_c3c3, 1'b0);
    key = 32'h5a5a_c3c3;
    for (int i = 0; i < 4; i++) ram_read(i[0], i);

    // Firmware RAM before and after application mode
    reg_read(1'b0, MODE_BASE + MODE_ID_REG * 4, MODE_ID_VALUE, 1'b0);
    for (int i = 0; i < 4; i++) begin
      fw_store[i] = next_rand();
      reg_write(1'b1, FW_BASE + i * 4, fw_store[i], 1'b0);
    end
    for (int i = 0; i < 4; i++) reg_read(1'b0, FW_BASE + i * 4, fw_store[i], 1'b0);
    reg_write(1'b1, MODE_BASE + MODE_APP_REG * 4, 32'h1, 1'b0);
    app_mode = 1'b1;
    reg_read(1'b0, MODE_BASE + MODE_APP_REG * 4, {31'h0, app_mode}, 1'b0);
    reg_write(1'b1, FW_BASE, 32'hdead_beef, app_mode);
    reg_read(1'b0, FW_BASE, fw_store[0], 1'b0);
    reg_write(1'b0, MODE_BASE + MODE_KEY_REG * 4, 32'h1234_5678, app_mode);
    ram_read(1'b1, 5);

    // Unmapped areas and core
    reg_read(1'b0, 32'h0000_0010, 32'h0, 1'b1);
    reg_read(1'b1, 32'h8000_0000, 32'h0, 1'b1);
    reg_read(1'b0, 32'hc500_0000, 32'h0, 1'b1);
    reg_write(1'b1, 32'hc500_0004, 32'h1, 1'b1);

    // Timer run to zero
    reg_write(1'b0, TIMER_BASE + TIMER_PRESCALE_REG * 4, 32'd3, 1'b0);
    reg_write(1'b0, TIMER_BASE + TIMER_INITIAL_REG * 4, 32'd20, 1'b0);
    reg_read(1'b1, TIMER_BASE + TIMER_PRESCALE_REG * 4, 32'd3, 1'b0);
    reg_read(1'b1, TIMER_BASE + TIMER_INITIAL_REG * 4, 32'd20, 1'b0);
    reg_write(1'b0, TIMER_BASE + TIMER_CTRL_REG * 4, 32'h1 << TIMER_START_BIT, 1'b0);
    t0 = $time;
    reg_read(1'b0, TIMER_BASE + TIMER_STATUS_REG * 4, 32'h1, 1'b0);
    bound = 20 * (3 + 1) + 8;
    do begin
      apb_xfer(1'b1, 1'b0, TIMER_BASE + TIMER_STATUS_REG * 4, 32'h0, 4'h0, stat, err);
      elapsed = int'(($time - t0) / 8);
    end while (stat[0] && elapsed < 2 * bound);
    expect_val("timer stop bound", {31'h0, elapsed <= bound}, 32'h1);
    apb_xfer(1'b1, 1'b0, TIMER_BASE + TIMER_COUNT_REG * 4, 32'h0, 4'h0, rd, err);
    expect_val("timer count", rd, 32'h0);

    wait (results.size() == 0);
    #1;
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: tb.f
bus_pkg.sv
reg_pkg.sv
apb_arbiter.sv
addr_decoder.sv
word_ram.sv
timer_core.sv
mode_ctrl.sv
app_soc_top.sv
tb_clock_gen.sv
tb_app_soc.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_app_soc -o sim_app_soc

# The simulation may stop with a nonzero status, the log decides
./obj_dir/sim_app_soc > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
